/* rv_core_pkg.sv */
// ====================
// Shared widths, enums and structs for the RV32I subset core
// ====================
package rv_core_pkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [REG_ADDR_W-1:0] reg_idx_t;

   // Major opcodes, bits [6:0] of the instruction
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_AUIPC  = 7'b0010111,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111,
      OPC_JALR   = 7'b1100111,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLTU,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_PASS_B
   } alu_op_e;

   // Same encoding as funct3[1:0] of loads and stores
   typedef enum logic [1:0] {
      MEM_BYTE = 2'b00,
      MEM_HALF = 2'b01,
      MEM_WORD = 2'b10
   } mem_size_e;

   typedef enum logic [1:0] {
      ST_FETCH,
      ST_EXECUTE,
      ST_MEMORY,
      ST_HALT
   } core_state_e;

   typedef struct packed {
      reg_idx_t  rs1;
      reg_idx_t  rs2;
      reg_idx_t  rd;
      word_t     imm;
      alu_op_e   alu_op;
      logic      a_is_pc;
      logic      b_is_imm;
      logic      is_branch;
      logic [2:0] branch_funct;
      logic      is_jal;
      logic      is_jalr;
      logic      is_load;
      logic      is_store;
      mem_size_e mem_size;
      logic      load_unsigned;
      logic      writes_rd;
      logic      illegal;
   } decoded_t;

   // Data port request, held stable until ready
   typedef struct packed {
      word_t      addr;
      word_t      wdata;
      logic [3:0] byte_en;
      mem_size_e  size;
      logic       write;
   } dmem_req_t;

endpackage

/* rv_decoder.sv */
// ====================
// Instruction decoder with fields, immediates and the control struct
// ====================
module rv_decoder
   import rv_core_pkg::*;
(
   input  word_t    instr,
   output decoded_t dec
);

   opcode_e    opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_u;
   word_t      imm_j;

   assign opcode = opcode_e'(instr[6:0]);
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   // ====================
   // Immediate rebuild
   // ====================
   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   // ALU operation from funct3 and the alt bit for sub and sra
   function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
      alu_op_e op;
      case (f3)
         3'b000:  op = alt ? ALU_SUB : ALU_ADD;
         3'b001:  op = ALU_SLL;
         3'b010:  op = ALU_SLT;
         3'b011:  op = ALU_SLTU;
         3'b100:  op = ALU_XOR;
         3'b101:  op = alt ? ALU_SRA : ALU_SRL;
         3'b110:  op = ALU_OR;
         default: op = ALU_AND;
      endcase
      return op;
   endfunction

   always_comb begin
      dec               = '0;
      dec.rs1           = instr[19:15];
      dec.rs2           = instr[24:20];
      dec.rd            = instr[11:7];
      dec.imm           = imm_i;
      dec.alu_op        = ALU_ADD;
      dec.branch_funct  = funct3;
      dec.mem_size      = mem_size_e'(funct3[1:0]);
      dec.load_unsigned = funct3[2];

      case (opcode)
         OPC_OP: begin
            dec.alu_op    = alu_from_funct(funct3, funct7[5]);
            dec.writes_rd = 1'b1;
            // Only sub and sra may use the alternate funct7
            dec.illegal   = !(funct7 == 7'b0000000 ||
                              (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
         end
         OPC_OP_IMM: begin
            dec.alu_op    = alu_from_funct(funct3, funct3 == 3'b101 && funct7[5]);
            dec.b_is_imm  = 1'b1;
            dec.writes_rd = 1'b1;
            if (funct3 == 3'b001) begin
               dec.illegal = funct7 != 7'b0000000;
            end else if (funct3 == 3'b101) begin
               dec.illegal = funct7 != 7'b0000000 && funct7 != 7'b0100000;
            end
         end
         OPC_LUI: begin
            dec.imm       = imm_u;
            dec.alu_op    = ALU_PASS_B;
            dec.b_is_imm  = 1'b1;
            dec.writes_rd = 1'b1;
         end
         OPC_AUIPC: begin
            dec.imm       = imm_u;
            dec.a_is_pc   = 1'b1;
            dec.b_is_imm  = 1'b1;
            dec.writes_rd = 1'b1;
         end
         OPC_BRANCH: begin
            dec.imm       = imm_b;
            dec.is_branch = 1'b1;
            // Unsigned compares are not supported
            dec.illegal   = funct3[1];
         end
         OPC_JAL: begin
            dec.imm       = imm_j;
            dec.is_jal    = 1'b1;
            dec.writes_rd = 1'b1;
         end
         OPC_JALR: begin
            dec.b_is_imm  = 1'b1;
            dec.is_jalr   = 1'b1;
            dec.writes_rd = 1'b1;
            dec.illegal   = funct3 != 3'b000;
         end
         OPC_LOAD: begin
            dec.b_is_imm  = 1'b1;
            dec.is_load   = 1'b1;
            dec.writes_rd = 1'b1;
            dec.illegal   = funct3[1:0] == 2'b11 || (funct3[2] && funct3[1]);
         end
         OPC_STORE: begin
            dec.imm       = imm_s;
            dec.b_is_imm  = 1'b1;
            dec.is_store  = 1'b1;
            dec.illegal   = funct3[2] || funct3[1:0] == 2'b11;
         end
         default: begin
            dec.illegal   = 1'b1;
         end
      endcase
   end

endmodule

/* rv_regfile.sv */
// ====================
// Register file, two read ports and one write port
// ====================
module rv_regfile
   import rv_core_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  reg_idx_t rs1,
   input  reg_idx_t rs2,
   input  reg_idx_t rd,
   input  logic     we,
   input  word_t    wdata,
   output word_t    rs1_data,
   output word_t    rs2_data
);

   localparam int NUM_REGS = 1 << REG_ADDR_W;

   word_t regs [NUM_REGS];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we && rd != '0) begin
         regs[rd] <= wdata;
      end
   end

   // x0 is hardwired
   assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
   assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* rv_alu.sv */
// ====================
// ALU with operand select and branch compare
// ====================
module rv_alu
   import rv_core_pkg::*;
(
   input  decoded_t dec,
   input  word_t    pc,
   input  word_t    rs1_data,
   input  word_t    rs2_data,
   output word_t    result,
   output logic     branch_cond
);

   word_t      op_a;
   word_t      op_b;
   logic [4:0] shamt;

   assign op_a  = dec.a_is_pc  ? pc      : rs1_data;
   assign op_b  = dec.b_is_imm ? dec.imm : rs2_data;
   assign shamt = op_b[4:0];

   always_comb begin
      case (dec.alu_op)
         ALU_ADD:    result = op_a + op_b;
         ALU_SUB:    result = op_a - op_b;
         ALU_AND:    result = op_a & op_b;
         ALU_OR:     result = op_a | op_b;
         ALU_XOR:    result = op_a ^ op_b;
         ALU_SLT:    result = {31'b0, $signed(op_a) < $signed(op_b)};
         ALU_SLTU:   result = {31'b0, op_a < op_b};
         ALU_SLL:    result = op_a << shamt;
         ALU_SRL:    result = op_a >> shamt;
         ALU_SRA:    result = word_t'($signed(op_a) >>> shamt);
         ALU_PASS_B: result = op_b;
         default:    result = op_a + op_b;
      endcase
   end

   // Branch compare always works on the register operands
   always_comb begin
      case (dec.branch_funct)
         3'b000:  branch_cond = rs1_data == rs2_data;
         3'b001:  branch_cond = rs1_data != rs2_data;
         3'b100:  branch_cond = $signed(rs1_data) < $signed(rs2_data);
         3'b101:  branch_cond = $signed(rs1_data) >= $signed(rs2_data);
         default: branch_cond = 1'b0;
      endcase
   end

endmodule

/* rv_lsu.sv */
// ====================
// Load/store unit with store lanes, byte enables and load extraction
// ====================
module rv_lsu
   import rv_core_pkg::*;
(
   input  decoded_t  dec,
   input  word_t     addr,
   input  word_t     rs2_data,
   input  word_t     dmem_rdata,
   output dmem_req_t dmem,
   output word_t     load_data
);

   logic [3:0] lane_en;
   word_t      store_data;
   word_t      rdata_shifted;

   // ====================
   // Store placement
   // ====================
   always_comb begin
      case (dec.mem_size)
         MEM_BYTE: begin
            store_data = {4{rs2_data[7:0]}};
            lane_en    = 4'b0001 << addr[1:0];
         end
         MEM_HALF: begin
            store_data = {2{rs2_data[15:0]}};
            lane_en    = addr[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            store_data = rs2_data;
            lane_en    = 4'b1111;
         end
      endcase
   end

   always_comb begin
      dmem.addr  = addr;
      dmem.wdata = store_data;
      dmem.size  = dec.mem_size;
      dmem.write = dec.is_store;
      // No enables on a read
      dmem.byte_en = dec.is_store ? lane_en : 4'b0000;
   end

   // ====================
   // Load extraction
   // ====================

   // Addressed lane moved down to bit 0
   assign rdata_shifted = dmem_rdata >> {addr[1:0], 3'b000};

   always_comb begin
      case (dec.mem_size)
         MEM_BYTE: begin
            if (dec.load_unsigned) begin
               load_data = {24'b0, rdata_shifted[7:0]};
            end else begin
               load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
            end
         end
         MEM_HALF: begin
            if (dec.load_unsigned) begin
               load_data = {16'b0, rdata_shifted[15:0]};
            end else begin
               load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
            end
         end
         default: begin
            load_data = dmem_rdata;
         end
      endcase
   end

endmodule

/* rv_control.sv */
// ====================
// Instruction FSM, program counter and write-back select
// ====================
module rv_control
   import rv_core_pkg::*;
#(
   parameter word_t RESET_PC = '0
)(
   input  logic     clk,
   input  logic     rst_n,
   input  word_t    imem_rdata,
   input  logic     imem_ready,
   input  logic     dmem_ready,
   input  decoded_t dec,
   input  word_t    alu_result,
   input  logic     branch_cond,
   input  word_t    load_data,
   output logic     imem_req,
   output word_t    imem_addr,
   output logic     dmem_req,
   output word_t    instr,
   output word_t    pc,
   output logic     rd_we,
   output word_t    rd_wdata,
   output logic     illegal_instruction
);

   // addi x0, x0, 0
   localparam word_t NOP = 32'h0000_0013;

   core_state_e state_q;
   core_state_e state_d;
   word_t       pc_q;
   word_t       instr_q;
   word_t       pc_plus4;
   word_t       next_pc;
   logic        mem_op;
   logic        retire;

   assign mem_op   = dec.is_load || dec.is_store;
   assign pc_plus4 = pc_q + 32'd4;

   // ====================
   // Next state
   // ====================
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_FETCH: begin
            if (imem_ready) state_d = ST_EXECUTE;
         end
         ST_EXECUTE: begin
            if (dec.illegal) state_d = ST_HALT;
            else if (mem_op) state_d = ST_MEMORY;
            else             state_d = ST_FETCH;
         end
         ST_MEMORY: begin
            if (dmem_ready) state_d = ST_FETCH;
         end
         default: state_d = ST_HALT;
      endcase
   end

   // Instruction completes here and the PC moves on
   assign retire = (state_q == ST_EXECUTE && !dec.illegal && !mem_op) ||
                   (state_q == ST_MEMORY && dmem_ready);

   always_comb begin
      if (dec.is_jalr) begin
         next_pc = {alu_result[XLEN-1:1], 1'b0};
      end else if (dec.is_jal || (dec.is_branch && branch_cond)) begin
         next_pc = pc_q + dec.imm;
      end else begin
         next_pc = pc_plus4;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= ST_FETCH;
         pc_q    <= RESET_PC;
         instr_q <= NOP;
      end else begin
         state_q <= state_d;
         if (state_q == ST_FETCH && imem_ready) instr_q <= imem_rdata;
         if (retire) pc_q <= next_pc;
      end
   end

   // ====================
   // Write-back
   // ====================
   always_comb begin
      if (dec.is_load) begin
         rd_wdata = load_data;
      end else if (dec.is_jal || dec.is_jalr) begin
         rd_wdata = pc_plus4;
      end else begin
         rd_wdata = alu_result;
      end
   end

   assign rd_we = retire && dec.writes_rd;

   assign imem_req            = state_q == ST_FETCH;
   assign imem_addr           = pc_q;
   assign dmem_req            = state_q == ST_MEMORY;
   assign illegal_instruction = state_q == ST_HALT;
   assign instr               = instr_q;
   assign pc                  = pc_q;

endmodule

/* rv_core.sv */
// ====================
// RV32I subset core top level
// ====================
module rv_core
   import rv_core_pkg::*;
#(
   parameter word_t RESET_PC = '0
)(
   input  logic      clk,
   input  logic      rst_n,
   // Code port
   output logic      imem_req,
   output word_t     imem_addr,
   input  word_t     imem_rdata,
   input  logic      imem_ready,
   // Data port
   output logic      dmem_req,
   output dmem_req_t dmem,
   input  word_t     dmem_rdata,
   input  logic      dmem_ready,
   output logic      illegal_instruction
);

   word_t    instr;
   word_t    pc;
   decoded_t dec;
   word_t    rs1_data;
   word_t    rs2_data;
   word_t    alu_result;
   logic     branch_cond;
   word_t    load_data;
   logic     rd_we;
   word_t    rd_wdata;

   rv_control #(
      .RESET_PC (RESET_PC)
   ) u_control (
      .clk                 (clk),
      .rst_n               (rst_n),
      .imem_rdata          (imem_rdata),
      .imem_ready          (imem_ready),
      .dmem_ready          (dmem_ready),
      .dec                 (dec),
      .alu_result          (alu_result),
      .branch_cond         (branch_cond),
      .load_data           (load_data),
      .imem_req            (imem_req),
      .imem_addr           (imem_addr),
      .dmem_req            (dmem_req),
      .instr               (instr),
      .pc                  (pc),
      .rd_we               (rd_we),
      .rd_wdata            (rd_wdata),
      .illegal_instruction (illegal_instruction)
   );

   rv_decoder u_decoder (
      .instr (instr),
      .dec   (dec)
   );

   rv_regfile u_regfile (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1      (dec.rs1),
      .rs2      (dec.rs2),
      .rd       (dec.rd),
      .we       (rd_we),
      .wdata    (rd_wdata),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data)
   );

   rv_alu u_alu (
      .dec         (dec),
      .pc          (pc),
      .rs1_data    (rs1_data),
      .rs2_data    (rs2_data),
      .result      (alu_result),
      .branch_cond (branch_cond)
   );

   // ALU result doubles as the data address
   rv_lsu u_lsu (
      .dec        (dec),
      .addr       (alu_result),
      .rs2_data   (rs2_data),
      .dmem_rdata (dmem_rdata),
      .dmem       (dmem),
      .load_data  (load_data)
   );

endmodule

/* tb_rv_mem.sv */
// ====================
// Code and data memory model with wait states and a store log
// ====================
module tb_rv_mem
   import rv_core_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       imem_req,
   input  word_t      imem_addr,
   output word_t      imem_rdata,
   output logic       imem_ready,
   input  logic       dmem_req,
   input  dmem_req_t  dmem,
   output word_t      dmem_rdata,
   output logic       dmem_ready,
   input  logic [3:0] wait_cycles
);
   timeunit 1ns;
   timeprecision 100ps;

   word_t      code [256];
   word_t      data [256];
   // One entry per completed store
   word_t      st_addr [$];
   logic [3:0] st_be [$];
   word_t      st_data [$];
   mem_size_e  st_size [$];
   logic [3:0] icnt;
   logic [3:0] dcnt;

   // Code fill decodes as an illegal opcode
   task automatic clear_memory();
      word_t a;
      for (int i = 0; i < 256; i++) begin
         a = word_t'(i * 4);
         code[i] = {a[24:0], 7'h7f};
         data[i] = {a[15:0] ^ 16'hc3a5, a[15:0]};
      end
   endtask

   task automatic put_code(input int idx, input word_t w);
      code[idx] = w;
   endtask

   task automatic put_data(input int idx, input word_t w);
      data[idx] = w;
   endtask

   always @(negedge clk or negedge rst_n) begin
      if (!rst_n) begin
         imem_ready <= 1'b0;
         dmem_ready <= 1'b0;
         imem_rdata <= '0;
         dmem_rdata <= '0;
         icnt = '0;
         dcnt = '0;
         st_addr.delete();
         st_be.delete();
         st_data.delete();
         st_size.delete();
      end else begin
         imem_ready <= 1'b0;
         dmem_ready <= 1'b0;
         if (imem_req && !imem_ready) begin
            if (icnt >= wait_cycles) begin
               imem_ready <= 1'b1;
               imem_rdata <= code[imem_addr[9:2]];
               icnt = '0;
            end else begin
               icnt = icnt + 4'd1;
            end
         end
         if (dmem_req && !dmem_ready) begin
            if (dcnt >= wait_cycles) begin
               dmem_ready <= 1'b1;
               dmem_rdata <= data[dmem.addr[9:2]];
               dcnt = '0;
               if (dmem.write) begin
                  for (int b = 0; b < 4; b++) begin
                     if (dmem.byte_en[b]) data[dmem.addr[9:2]][8*b +: 8] = dmem.wdata[8*b +: 8];
                  end
                  st_addr.push_back(dmem.addr);
                  st_be.push_back(dmem.byte_en);
                  st_data.push_back(dmem.wdata);
                  st_size.push_back(dmem.size);
               end
            end else begin
               dcnt = dcnt + 4'd1;
            end
         end
      end
   end

endmodule

/* rv_core_props.sv */
// ====================
// Bus protocol assertions bound into rv_core
// ====================
module rv_core_props
   import rv_core_pkg::*;
(
   input logic      clk,
   input logic      rst_n,
   input logic      imem_req,
   input word_t     imem_addr,
   input logic      imem_ready,
   input logic      dmem_req,
   input dmem_req_t dmem,
   input logic      dmem_ready,
   input logic      illegal_instruction
);
   timeunit 1ns;
   timeprecision 100ps;

   one_port_at_a_time: assert property (@(posedge clk) disable iff (!rst_n)
      !(imem_req && dmem_req)) else $error("both ports requested");

   // Request held with stable address until ready
   imem_held: assert property (@(posedge clk) disable iff (!rst_n)
      imem_req && !imem_ready |=> imem_req && $stable(imem_addr)) else $error("imem request dropped");

   dmem_held: assert property (@(posedge clk) disable iff (!rst_n)
      dmem_req && !dmem_ready |=> dmem_req && $stable(dmem)) else $error("dmem request dropped");

   enables_on_write: assert property (@(posedge clk) disable iff (!rst_n)
      dmem_req |-> ((dmem.byte_en != 4'b0000) == dmem.write)) else $error("byte enables wrong");

   // Once halted the core stays halted with both ports idle
   halted_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      illegal_instruction |=> illegal_instruction && !imem_req && !dmem_req)
      else $error("request after halt");

endmodule

bind rv_core rv_core_props u_props (
   .clk                 (clk),
   .rst_n               (rst_n),
   .imem_req            (imem_req),
   .imem_addr           (imem_addr),
   .imem_ready          (imem_ready),
   .dmem_req            (dmem_req),
   .dmem                (dmem),
   .dmem_ready          (dmem_ready),
   .illegal_instruction (illegal_instruction)
);

/* tb_rv_core.sv */
// ====================
// Testbench top with clock, reset, program loader and directed tests
// ====================
module tb_rv_core
   import rv_core_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam word_t START_PC = 32'h0000_0100;
   localparam word_t DONE_ADDR = 32'h3fc;
   localparam int    TIMEOUT = 4000;

   logic       clk = 1'b0;
   logic       rst_n;
   logic       imem_req;
   word_t      imem_addr;
   word_t      imem_rdata;
   logic       imem_ready;
   logic       dmem_req;
   dmem_req_t  dmem;
   word_t      dmem_rdata;
   logic       dmem_ready;
   logic       illegal_instruction;
   logic [3:0] wait_cyc;

   word_t prog [$];
   word_t exp_addr [$];
   word_t exp_val [$];
   word_t absent_addr [$];
   word_t slot;

   always #2 clk = ~clk;

   rv_core #(.RESET_PC(START_PC)) UUT (
      .clk (clk), .rst_n (rst_n),
      .imem_req (imem_req), .imem_addr (imem_addr),
      .imem_rdata (imem_rdata), .imem_ready (imem_ready),
      .dmem_req (dmem_req), .dmem (dmem),
      .dmem_rdata (dmem_rdata), .dmem_ready (dmem_ready),
      .illegal_instruction (illegal_instruction)
   );

   tb_rv_mem mem (
      .clk (clk), .rst_n (rst_n),
      .imem_req (imem_req), .imem_addr (imem_addr),
      .imem_rdata (imem_rdata), .imem_ready (imem_ready),
      .dmem_req (dmem_req), .dmem (dmem),
      .dmem_rdata (dmem_rdata), .dmem_ready (dmem_ready),
      .wait_cycles (wait_cyc)
   );

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "test stopped");
   endtask

   // ====================
   // Instruction encoders
   // ====================
   function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2, input logic [2:0] f3);
      return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'h23};
   endfunction

   function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                   input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
   endfunction

   function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
   endfunction

   function automatic word_t cur_pc();
      return START_PC + word_t'(prog.size() * 4);
   endfunction

   // RV32I result rules
   function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
                                     input word_t b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3:    return (a < b) ? 32'd1 : 32'd0;
         3'd4:    return a ^ b;
         3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         default: return $signed(a) >= $signed(b);
      endcase
   endfunction

   function automatic int find_store(input word_t addr);
      for (int i = 0; i < mem.st_addr.size(); i++) begin
         if (mem.st_addr[i] == addr) return i;
      end
      return -1;
   endfunction

   // ====================
   // Program building and running
   // ====================
   task automatic emit_const(input reg_idx_t rd, input word_t v);
      word_t hi;
      hi = v + 32'h800;
      prog.push_back({hi[31:12], rd, 7'h37});
      prog.push_back(enc_i(v[11:0], rd, 3'd0, rd, 7'h13));
   endtask

   task automatic store_slot(input reg_idx_t rs, output word_t addr);
      addr = slot;
      prog.push_back(enc_s(slot[11:0], rs, 3'b010));
      slot = slot + 32'd4;
   endtask

   task automatic expect_store(input reg_idx_t rs, input word_t val);
      word_t a;
      store_slot(rs, a);
      exp_addr.push_back(a);
      exp_val.push_back(val);
   endtask

   task automatic start_test();
      @(negedge clk);
      rst_n = 1'b0;
      mem.clear_memory();
      prog.delete();
      exp_addr.delete();
      exp_val.delete();
      absent_addr.delete();
      slot = 32'h200;
   endtask

   task automatic load_and_reset();
      for (int i = 0; i < prog.size(); i++) mem.put_code(int'(START_PC >> 2) + i, prog[i]);
      wait_cyc = 4'($urandom_range(3, 0));
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
   endtask

   task automatic run_program();
      int cyc;
      prog.push_back(enc_s(DONE_ADDR[11:0], 5'd0, 3'b010));
      load_and_reset();
      for (cyc = 0; cyc < TIMEOUT && find_store(DONE_ADDR) < 0; cyc++) begin
         @(negedge clk);
         assert (!illegal_instruction) else fail_now("Core halted on an unexpected illegal instruction");
      end
      assert (cyc < TIMEOUT) else fail_now("Timeout waiting for the program to finish");
   endtask

   task automatic check_stores();
      int idx;
      for (int i = 0; i < exp_addr.size(); i++) begin
         idx = find_store(exp_addr[i]);
         assert (idx >= 0) else fail_now($sformatf("No store seen at address 0x%08h", exp_addr[i]));
         assert (mem.st_data[idx] == exp_val[i]) else fail_now($sformatf(
            "Mismatch dmem.wdata @0x%08h: got 0x%08h expected 0x%08h",
            exp_addr[i], mem.st_data[idx], exp_val[i]));
         assert (mem.st_size[idx] == MEM_WORD) else fail_now($sformatf(
            "Mismatch dmem.size @0x%08h: got 0x%01h expected 0x%01h",
            exp_addr[i], mem.st_size[idx], MEM_WORD));
      end
      foreach (absent_addr[i]) begin
         assert (find_store(absent_addr[i]) < 0) else fail_now($sformatf(
            "Store on a path that should be skipped, address 0x%08h", absent_addr[i]));
      end
   endtask

   // ====================
   // Directed tests
   // ====================
   task automatic test_reset();
      start_test();
      load_and_reset();
      assert (imem_req) else fail_now("No fetch request after reset");
      assert (imem_addr == START_PC) else fail_now($sformatf(
         "Mismatch imem_addr: got 0x%08h expected 0x%08h", imem_addr, START_PC));
      assert (!dmem_req) else fail_now("dmem_req high after reset");
      assert (!illegal_instruction) else fail_now("illegal_instruction high after reset");
   endtask

   task automatic test_arith();
      word_t       a;
      word_t       b;
      logic [11:0] imm;
      logic        alt;
      word_t       pc;
      start_test();
      a = $urandom();
      b = $urandom();
      emit_const(5'd1, a);
      emit_const(5'd2, b);
      for (int k = 0; k < 10; k++) begin
         alt = k >= 8;
         prog.push_back(enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, 3'(k == 9 ? 5 : k % 8), 5'd3));
         expect_store(5'd3, alu_ref(3'(k == 9 ? 5 : k % 8), alt, a, b));
      end
      for (int k = 0; k < 9; k++) begin
         alt = k == 8;
         imm = 12'($urandom());
         if (k == 1 || k == 5 || k == 8) imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
         prog.push_back(enc_i(imm, 5'd1, 3'(k == 8 ? 5 : k), 5'd3, 7'h13));
         expect_store(5'd3, alu_ref(3'(k == 8 ? 5 : k), alt, a, {{20{imm[11]}}, imm}));
      end
      prog.push_back({b[31:12], 5'd4, 7'h37});
      expect_store(5'd4, {b[31:12], 12'h0});
      pc = cur_pc();
      prog.push_back({a[31:12], 5'd5, 7'h17});
      expect_store(5'd5, pc + {a[31:12], 12'h0});
      run_program();
      check_stores();
   endtask

   task automatic test_stores();
      word_t v;
      word_t addr;
      int    idx;
      logic [3:0] be;
      mem_size_e  sz;
      start_test();
      v = $urandom();
      emit_const(5'd1, v);
      for (int k = 0; k < 6; k++) begin
         addr = 32'h100 + word_t'(k * 8) + word_t'(k < 4 ? k : (k - 4) * 2);
         prog.push_back(enc_s(addr[11:0], 5'd1, k < 4 ? 3'd0 : 3'd1));
      end
      run_program();
      for (int k = 0; k < 6; k++) begin
         addr = 32'h100 + word_t'(k * 8) + word_t'(k < 4 ? k : (k - 4) * 2);
         be = (k < 4) ? 4'b0001 << addr[1:0] : 4'b0011 << addr[1:0];
         sz = (k < 4) ? MEM_BYTE : MEM_HALF;
         idx = find_store(addr);
         assert (idx >= 0) else fail_now($sformatf("No store seen at address 0x%08h", addr));
         assert (mem.st_be[idx] == be) else fail_now($sformatf(
            "Mismatch dmem.byte_en: got 0x%01h expected 0x%01h", mem.st_be[idx], be));
         assert (mem.st_size[idx] == sz) else fail_now($sformatf(
            "Mismatch dmem.size: got 0x%01h expected 0x%01h", mem.st_size[idx], sz));
         for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
               assert (mem.st_data[idx][8*b +: 8] == v[8*(b - int'(addr[1:0])) +: 8])
                  else fail_now($sformatf("Mismatch dmem.wdata lane %0d: got 0x%08h value 0x%08h",
                                          b, mem.st_data[idx], v));
            end
         end
      end
   endtask

   task automatic test_loads();
      word_t w;
      word_t lane;
      start_test();
      w = $urandom();
      mem.put_data(32, w);
      for (int k = 0; k < 12; k++) begin
         // Bytes at four offsets, then halves at two, signed then unsigned
         lane = (k % 6 < 4) ? w >> (8 * (k % 6)) : w >> (16 * (k % 6 - 4));
         prog.push_back(enc_i(12'h080 + 12'(k % 6 < 4 ? k % 6 : (k % 6 - 4) * 2), 5'd0,
                              {k >= 6, 1'b0, k % 6 >= 4}, 5'd3, 7'h03));
         if (k % 6 < 4) begin
            expect_store(5'd3, k >= 6 ? {24'h0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]});
         end else begin
            expect_store(5'd3, k >= 6 ? {16'h0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]});
         end
      end
      run_program();
      check_stores();
   endtask

   task automatic test_control();
      word_t       r [2];
      word_t       a;
      word_t       p;
      logic [2:0]  f3;
      start_test();
      r[0] = $urandom();
      r[1] = $urandom();
      emit_const(5'd1, r[0]);
      emit_const(5'd2, r[1]);
      prog.push_back(enc_i(12'h011, 5'd0, 3'd0, 5'd3, 7'h13));
      for (int k = 0; k < 12; k++) begin
         f3 = (k / 3 < 2) ? 3'(k / 3) : 3'(k / 3 + 2);
         // Pairs (x1,x2), (x2,x1), (x1,x1)
         prog.push_back(enc_b(13'd12, k % 3 == 0 ? 5'd2 : 5'd1, k % 3 == 1 ? 5'd2 : 5'd1, f3));
         store_slot(5'd3, a);
         if (branch_ref(f3, r[k % 3 == 1 ? 1 : 0], r[k % 3 == 0 ? 1 : 0])) begin
            absent_addr.push_back(a);
            prog.push_back(enc_j(21'd8, 5'd0));
            expect_store(5'd3, 32'h11);
         end else begin
            exp_addr.push_back(a);
            exp_val.push_back(32'h11);
            prog.push_back(enc_j(21'd8, 5'd0));
            store_slot(5'd3, a);
            absent_addr.push_back(a);
         end
      end
      p = cur_pc();
      prog.push_back(enc_j(21'd8, 5'd6));
      store_slot(5'd3, a);
      absent_addr.push_back(a);
      expect_store(5'd6, p + 32'd4);
      p = cur_pc();
      // Target has bit 0 set, which jalr clears
      prog.push_back(enc_i(12'(p + 32'd13), 5'd0, 3'd0, 5'd7, 7'h13));
      prog.push_back(enc_i(12'h0, 5'd7, 3'd0, 5'd8, 7'h67));
      store_slot(5'd3, a);
      absent_addr.push_back(a);
      expect_store(5'd8, p + 32'd8);
      run_program();
      check_stores();
   endtask

   task automatic test_illegal();
      int cyc;
      start_test();
      // mul x3, x1, x2
      prog.push_back(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd3));
      expect_store(5'd3, 32'h0);
      load_and_reset();
      for (cyc = 0; cyc < TIMEOUT && !illegal_instruction; cyc++) @(negedge clk);
      assert (cyc < TIMEOUT) else fail_now("Timeout waiting for illegal_instruction");
      for (int i = 0; i < 50; i++) begin
         @(negedge clk);
         assert (!imem_req) else fail_now("Fetch request after the core halted");
         assert (mem.st_addr.size() == 0) else fail_now("Store seen after an illegal instruction");
      end
   endtask

   initial begin
      rst_n = 1'b0;
      wait_cyc = 4'd0;
      void'($urandom(32'h7b00_3c1c));
      test_reset();
      test_arith();
      test_stores();
      test_loads();
      test_control();
      test_illegal();
      $display("Result: PASSED");
      $finish;
   end

endmodule

/* list.f */
rv_core_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_lsu.sv
rv_control.sv
rv_core.sv
tb_rv_mem.sv
rv_core_props.sv
tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f list.f
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
